// ==== source/exu_pkg.sv ====
package exu_pkg;

    // ************************************************
    // datapath widths and lane count
    // ************************************************
    localparam int XLEN       = 64;
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;

    // restoring divider, one quotient bit per cycle
    localparam int DIV_STEPS  = XLEN;
    localparam int DIV_CNT_W  = $clog2(DIV_STEPS);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DIV_CNT_W-1:0]  div_cnt_t;

    // step count value of the final divide cycle
    localparam div_cnt_t DIV_LAST = div_cnt_t'(DIV_STEPS - 1);

    // ************************************************
    // operations
    // ************************************************
    typedef enum logic [4:0] {
        // full width
        OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
        OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
        OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        // word forms, result sign-extended from bit 31
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW
    } exu_op_e;

    // lane FSM
    typedef enum logic [1:0] {
        L_IDLE,
        L_DIVIDE,
        L_HOLD,   // res_req up, waiting for res_ack
        L_DRAIN   // res_req down, waiting for res_ack to fall
    } lane_state_e;

    // dispatcher FSM
    typedef enum logic [1:0] {
        D_IDLE,
        D_ISSUE,
        D_ACKED,
        D_RELEASE
    } disp_state_e;

endpackage

// ==== source/exu_lane_if.sv ====
interface exu_lane_if
    import exu_pkg::*;
();

    // issue side, dispatcher to lane
    logic      issue_req;
    logic      issue_ack;
    exu_op_e   issue_op;
    xlen_t     issue_a;
    xlen_t     issue_b;
    reg_addr_t issue_rd;

    // result side, lane to retire unit
    logic      res_req;
    logic      res_ack;
    xlen_t     res_value;
    reg_addr_t res_rd;

    modport dispatch (
        output issue_req, issue_op, issue_a, issue_b, issue_rd,
        input  issue_ack
    );

    modport lane (
        input  issue_req, issue_op, issue_a, issue_b, issue_rd, res_ack,
        output issue_ack, res_req, res_value, res_rd
    );

    modport retire (
        input  res_req, res_value, res_rd,
        output res_ack
    );

endinterface

// ==== source/exu_dispatch.sv ====
module exu_dispatch
    import exu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        op_req,
    output logic        op_ack,
    input  exu_op_e     op_code,
    input  xlen_t       op_a,
    input  xlen_t       op_b,
    input  reg_addr_t   op_rd,
    exu_lane_if.dispatch lanes [NUM_LANES]
);

    disp_state_e           state;
    logic [LANE_IDX_W-1:0] ptr;
    logic [NUM_LANES-1:0]  ack_vec;
    logic                  issuing;

    // captured operation, broadcast to every lane
    exu_op_e               op_q;
    xlen_t                 a_q;
    xlen_t                 b_q;
    reg_addr_t             rd_q;

    // req held from issue until op_req has dropped
    assign issuing = (state == D_ISSUE) || (state == D_ACKED);

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane_tap
        assign ack_vec[i]         = lanes[i].issue_ack;
        assign lanes[i].issue_req = issuing && (ptr == LANE_IDX_W'(i));
        assign lanes[i].issue_op  = op_q;
        assign lanes[i].issue_a   = a_q;
        assign lanes[i].issue_b   = b_q;
        assign lanes[i].issue_rd  = rd_q;
    end

    // ************************************************
    // handshake relay
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= D_IDLE;
            ptr    <= '0;
            op_ack <= 1'b0;
        end else begin
            case (state)
                // target lane must have dropped its previous ack
                D_IDLE: if (op_req && !ack_vec[ptr]) state <= D_ISSUE;
                D_ISSUE: begin
                    if (ack_vec[ptr]) begin
                        op_ack <= 1'b1;
                        state  <= D_ACKED;
                    end
                end
                D_ACKED: if (!op_req) state <= D_RELEASE;
                D_RELEASE: begin
                    // lane cycle closed, move to next lane
                    if (!ack_vec[ptr]) begin
                        op_ack <= 1'b0;
                        ptr    <= (ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
                        state  <= D_IDLE;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // capture on the way into D_ISSUE
    always_ff @(posedge clk) begin
        if (state == D_IDLE && op_req && !ack_vec[ptr]) begin
            op_q <= op_code;
            a_q  <= op_a;
            b_q  <= op_b;
            rd_q <= op_rd;
        end
    end

endmodule

// ==== source/exu_lane.sv ====
module exu_lane
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    exu_lane_if.lane port
);

    lane_state_e   state;
    logic          pending;
    div_cnt_t      step_cnt;
    exu_op_e       op_q;
    xlen_t         a_q;
    xlen_t         b_q;
    reg_addr_t     rd_q;
    // divider state
    xlen_t         quo;
    xlen_t         rem;
    xlen_t         dvs;
    logic          q_neg;
    logic          r_neg;
    logic          dvs_zero;
    logic [XLEN:0] trial;
    logic          take;
    xlen_t         quo_next;
    xlen_t         rem_next;
    // decode and results
    logic          accept;
    logic          start_div;
    logic          finish_alu;
    logic          finish_div;
    logic          word_op;
    logic          div_op;
    logic          signed_div;
    logic          a_neg;
    logic          b_neg;
    xlen_t         a_ext;
    xlen_t         b_ext;
    xlen_t         alu_raw;
    xlen_t         alu_res;
    xlen_t         q_fix;
    xlen_t         r_fix;
    xlen_t         div_raw;
    xlen_t         div_res;

    function automatic xlen_t sext_word(input xlen_t v);
        return {{(XLEN-WORD_W){v[WORD_W-1]}}, v[WORD_W-1:0]};
    endfunction

    assign accept     = (state == L_IDLE) && !pending && port.issue_req && !port.issue_ack;
    assign start_div  = (state == L_IDLE) && pending && div_op;
    assign finish_alu = (state == L_IDLE) && pending && !div_op;
    assign finish_div = (state == L_DIVIDE) && (step_cnt == DIV_LAST);

    always_comb begin
        word_op    = op_q inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                                  OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
        div_op     = op_q inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                                  OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
        signed_div = op_q inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
        // word divides use the 64-bit datapath on extended operands
        if (word_op && signed_div) begin
            a_ext = sext_word(a_q);
            b_ext = sext_word(b_q);
        end else if (word_op) begin
            a_ext = {{(XLEN-WORD_W){1'b0}}, a_q[WORD_W-1:0]};
            b_ext = {{(XLEN-WORD_W){1'b0}}, b_q[WORD_W-1:0]};
        end else begin
            a_ext = a_q;
            b_ext = b_q;
        end
        a_neg = signed_div && a_ext[XLEN-1];
        b_neg = signed_div && b_ext[XLEN-1];
    end

    // ************************************************
    // single-cycle ALU and multiply
    // ************************************************
    always_comb begin
        case (op_q)
            OP_ADD, OP_ADDW: alu_raw = a_q + b_q;
            OP_SUB, OP_SUBW: alu_raw = a_q - b_q;
            OP_SLL:          alu_raw = a_q << b_q[5:0];
            OP_SRL:          alu_raw = a_q >> b_q[5:0];
            OP_SRA:          alu_raw = xlen_t'($signed(a_q) >>> b_q[5:0]);
            OP_SLT:          alu_raw = xlen_t'($signed(a_q) < $signed(b_q));
            OP_SLTU:         alu_raw = xlen_t'(a_q < b_q);
            OP_XOR:          alu_raw = a_q ^ b_q;
            OP_OR:           alu_raw = a_q | b_q;
            OP_AND:          alu_raw = a_q & b_q;
            // low 64 bits of the product, low word for MULW
            OP_MUL, OP_MULW: alu_raw = a_q * b_q;
            OP_SLLW:         alu_raw = a_q << b_q[4:0];
            // fill from bit 31
            OP_SRLW:         alu_raw = xlen_t'(a_q[WORD_W-1:0] >> b_q[4:0]);
            OP_SRAW:         alu_raw = xlen_t'($signed(a_q[WORD_W-1:0]) >>> b_q[4:0]);
            default:         alu_raw = '0;
        endcase
        alu_res = word_op ? sext_word(alu_raw) : alu_raw;
    end

    // ************************************************
    // restoring divider step and fix-up
    // ************************************************
    always_comb begin
        // shift next dividend bit in, try the subtract
        trial    = {rem, quo[XLEN-1]} - {1'b0, dvs};
        take     = ~trial[XLEN];
        rem_next = take ? trial[XLEN-1:0] : {rem[XLEN-2:0], quo[XLEN-1]};
        quo_next = {quo[XLEN-2:0], take};
        q_fix    = q_neg ? -quo_next : quo_next;
        // remainder follows dividend sign
        r_fix    = r_neg ? -rem_next : rem_next;
        // divide by zero
        // remainder already comes out as the dividend, overflow also falls out
        if (dvs_zero) q_fix = '1;
        div_raw  = (op_q inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW}) ? q_fix : r_fix;
        div_res  = word_op ? sext_word(div_raw) : div_raw;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= L_IDLE;
            pending        <= 1'b0;
            step_cnt       <= '0;
            port.issue_ack <= 1'b0;
            port.res_req   <= 1'b0;
        end else begin
            if (accept) begin
                port.issue_ack <= 1'b1;
                pending        <= 1'b1;
            end else if (!port.issue_req) begin
                port.issue_ack <= 1'b0;
            end
            case (state)
                L_IDLE: begin
                    if (pending) begin
                        pending <= 1'b0;
                        if (div_op) begin
                            step_cnt <= '0;
                            state    <= L_DIVIDE;
                        end else begin
                            port.res_req <= 1'b1;
                            state        <= L_HOLD;
                        end
                    end
                end
                L_DIVIDE: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (finish_div) begin
                        port.res_req <= 1'b1;
                        state        <= L_HOLD;
                    end
                end
                L_HOLD: begin
                    if (port.res_ack) begin
                        port.res_req <= 1'b0;
                        state        <= L_DRAIN;
                    end
                end
                L_DRAIN: if (!port.res_ack) state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

    // operands, divider registers and result hold
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= port.issue_op;
            a_q  <= port.issue_a;
            b_q  <= port.issue_b;
            rd_q <= port.issue_rd;
        end
        if (start_div) begin
            quo      <= a_neg ? -a_ext : a_ext;
            rem      <= '0;
            dvs      <= b_neg ? -b_ext : b_ext;
            q_neg    <= a_neg ^ b_neg;
            r_neg    <= a_neg;
            dvs_zero <= (b_ext == '0);
        end else if (state == L_DIVIDE) begin
            quo <= quo_next;
            rem <= rem_next;
        end
        if (finish_alu || finish_div) begin
            port.res_value <= finish_div ? div_res : alu_res;
            port.res_rd    <= rd_q;
        end
    end

endmodule

// ==== source/exu_retire.sv ====
module exu_retire
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    exu_lane_if.retire lanes [NUM_LANES],
    output logic       res_req,
    input  logic       res_ack,
    output xlen_t      res_value,
    output reg_addr_t  res_rd
);

    logic [LANE_IDX_W-1:0] ptr;
    // res_ack toward the lane at ptr
    logic                  ack_q;
    logic                  load;
    logic [NUM_LANES-1:0]  req_vec;
    xlen_t                 value_arr [NUM_LANES];
    reg_addr_t             rd_arr [NUM_LANES];

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane_tap
        assign req_vec[i]       = lanes[i].res_req;
        assign value_arr[i]     = lanes[i].res_value;
        assign rd_arr[i]        = lanes[i].res_rd;
        assign lanes[i].res_ack = ack_q && (ptr == LANE_IDX_W'(i));
    end

    // new result only once top-level ack is back low
    assign load = !res_req && !ack_q && req_vec[ptr] && !res_ack;

    // ************************************************
    // in-order drain
    // ************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            res_req <= 1'b0;
            ack_q   <= 1'b0;
            ptr     <= '0;
        end else if (res_req) begin
            // consumer took it, pass ack back to the lane
            if (res_ack) begin
                res_req <= 1'b0;
                ack_q   <= 1'b1;
            end
        end else if (ack_q) begin
            // lane released its result
            if (!req_vec[ptr]) begin
                ack_q <= 1'b0;
                ptr   <= (ptr == LANE_IDX_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
            end
        end else if (load) begin
            res_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_value <= value_arr[ptr];
            res_rd    <= rd_arr[ptr];
        end
    end

endmodule

// ==== source/exu_top.sv ====
module exu_top
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // operation in
    input  logic      op_req,
    output logic      op_ack,
    input  exu_op_e   op_code,
    input  xlen_t     op_a,
    input  xlen_t     op_b,
    input  reg_addr_t op_rd,
    // result out, issue order
    output logic      res_req,
    input  logic      res_ack,
    output xlen_t     res_value,
    output reg_addr_t res_rd
);

    // one handshake bundle per lane
    exu_lane_if lane_bus [NUM_LANES] ();

    exu_dispatch u_dispatch (
        .clk     (clk),
        .rst     (rst),
        .op_req  (op_req),
        .op_ack  (op_ack),
        .op_code (op_code),
        .op_a    (op_a),
        .op_b    (op_b),
        .op_rd   (op_rd),
        .lanes   (lane_bus)
    );

    // identical lanes, round-robin served
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
        exu_lane u_lane (
            .clk  (clk),
            .rst  (rst),
            .port (lane_bus[g])
        );
    end

    exu_retire u_retire (
        .clk       (clk),
        .rst       (rst),
        .lanes     (lane_bus),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res_value (res_value),
        .res_rd    (res_rd)
    );

endmodule

// ==== verification/exu_assert.sv ====
module exu_assert
    import exu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      op_req,
    input logic      op_ack,
    input logic      res_req,
    input logic      res_ack,
    input xlen_t     res_value,
    input reg_addr_t res_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    // count of failed assertions
    int unsigned fail_cnt = 0;

    // ************************************************
    // top-level four-phase rules
    // ************************************************

    // ack only answers a pending request
    op_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(op_ack) |-> op_req)
        else begin
            fail_cnt++;
            $error("op_ack rose while op_req was low");
        end

    // result request held until acknowledged
    res_req_held: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> res_req)
        else begin
            fail_cnt++;
            $error("res_req fell before res_ack");
        end

    // payload frozen while waiting
    res_data_stable: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> $stable(res_value) && $stable(res_rd))
        else begin
            fail_cnt++;
            $error("res_value or res_rd changed while waiting for res_ack");
        end

    // consumer releases ack only after req is gone
    res_ack_held: assert property (@(posedge clk) disable iff (rst)
        res_ack && res_req |=> res_ack)
        else begin
            fail_cnt++;
            $error("res_ack fell while res_req was still high");
        end

endmodule

bind exu_top exu_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .op_req    (op_req),
    .op_ack    (op_ack),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .res_value (res_value),
    .res_rd    (res_rd)
);

// ==== verification/tb_exu.sv ====
module tb_exu
    import exu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    N_ALU          = 60;
    localparam int    N_WORD         = 60;
    localparam int    N_MULDIV       = 60;
    localparam int    N_CORNER       = 16;
    localparam int    N_MIXED        = 80;
    localparam int    TOTAL_OPS      = N_ALU + N_WORD + N_MULDIV + N_CORNER + N_MIXED;
    localparam int    TIMEOUT_CYCLES = TOTAL_OPS * (DIV_STEPS + 20);
    localparam xlen_t MOST_NEG       = {1'b1, {(XLEN-1){1'b0}}};

    logic      clk;
    logic      rst;
    logic      op_req;
    logic      op_ack;
    exu_op_e   op_code;
    xlen_t     op_a;
    xlen_t     op_b;
    reg_addr_t op_rd;
    logic      res_req;
    logic      res_ack;
    xlen_t     res_value;
    reg_addr_t res_rd;

    // expected results, oldest first
    xlen_t     exp_val [$];
    reg_addr_t exp_rd [$];

    logic [31:0] stim_lfsr  = 32'h49a8;
    logic [31:0] delay_lfsr = 32'h49a8;
    int          ack_max_delay = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    exu_op_e alu_ops [10] = '{OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
                              OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND};
    exu_op_e word_ops [5] = '{OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW};
    exu_op_e muldiv_ops [10] = '{OP_MUL, OP_MULW, OP_DIV, OP_DIVU, OP_REM,
                                 OP_REMU, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    exu_op_e div_ops [8] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                             OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

    exu_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .op_req    (op_req),
        .op_ack    (op_ack),
        .op_code   (op_code),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_rd     (op_rd),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res_value (res_value),
        .res_rd    (res_rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // compare mismatches plus handshake assertion failures
    function automatic int total_errors();
        return errors + int'(u_dut.u_assert.fail_cnt);
    endfunction

    // ************************************************
    // random source
    // ************************************************
    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic xlen_t stim_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    // separate stream for res_ack stalls
    function automatic int delay_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(delay_lfsr[0]);
            delay_lfsr = lfsr_step(delay_lfsr);
        end
        return v;
    endfunction

    // half corners, half fully random
    function automatic xlen_t pick_operand();
        logic [2:0] sel;
        xlen_t      r;
        sel = 3'(stim_bits(3));
        r   = stim_bits(XLEN);
        case (sel)
            3'd0: r = '0;
            3'd1: r = '1;
            3'd2: r = MOST_NEG;
            // most negative word, random upper half
            3'd3: r[WORD_W-1:0] = 32'h8000_0000;
            default: ;
        endcase
        return r;
    endfunction

    // kind 3 mixes all groups, weighted toward mul and divide
    function automatic exu_op_e pick_op(input int kind);
        int k;
        k = (kind == 3) ? int'(stim_bits(2)) : kind;
        case (k)
            0: return alu_ops[int'(stim_bits(8)) % 10];
            1: return word_ops[int'(stim_bits(8)) % 5];
            default: return muldiv_ops[int'(stim_bits(8)) % 10];
        endcase
    endfunction

    // ************************************************
    // reference model
    // ************************************************
    function automatic xlen_t ref_exu(input exu_op_e op, input xlen_t a, input xlen_t b);
        logic signed [XLEN-1:0]   sa;
        logic signed [XLEN-1:0]   sb;
        logic [WORD_W-1:0]        wa;
        logic [WORD_W-1:0]        wb;
        logic signed [WORD_W-1:0] swa;
        logic signed [WORD_W-1:0] swb;
        logic [WORD_W-1:0]        w;
        logic                     ovf;
        logic                     wovf;
        xlen_t                    r;
        sa   = a;
        sb   = b;
        wa   = a[WORD_W-1:0];
        wb   = b[WORD_W-1:0];
        swa  = wa;
        swb  = wb;
        ovf  = (a == MOST_NEG) && (b == '1);
        wovf = (wa == 32'h8000_0000) && (wb == '1);
        r    = '0;
        w    = '0;
        case (op)
            OP_ADD:   r = a + b;
            OP_SUB:   r = a - b;
            OP_SLL:   r = a << b[5:0];
            OP_SRL:   r = a >> b[5:0];
            OP_SRA:   r = sa >>> b[5:0];
            OP_SLT:   r = (sa < sb) ? 64'd1 : 64'd0;
            OP_SLTU:  r = (a < b) ? 64'd1 : 64'd0;
            OP_XOR:   r = a ^ b;
            OP_OR:    r = a | b;
            OP_AND:   r = a & b;
            OP_MUL:   r = a * b;
            OP_DIV: begin
                if (b == '0) r = '1;
                else if (ovf) r = a;
                else r = sa / sb;
            end
            OP_DIVU:  r = (b == '0) ? '1 : a / b;
            OP_REM: begin
                if (b == '0) r = a;
                else if (ovf) r = '0;
                else r = sa % sb;
            end
            OP_REMU:  r = (b == '0) ? a : a % b;
            // word forms produce w, extended below
            OP_ADDW:  w = wa + wb;
            OP_SUBW:  w = wa - wb;
            OP_SLLW:  w = wa << b[4:0];
            OP_SRLW:  w = wa >> b[4:0];
            OP_SRAW:  w = swa >>> b[4:0];
            OP_MULW:  w = wa * wb;
            OP_DIVW: begin
                if (wb == '0) w = '1;
                else if (wovf) w = wa;
                else w = swa / swb;
            end
            OP_DIVUW: w = (wb == '0) ? '1 : wa / wb;
            OP_REMW: begin
                if (wb == '0) w = wa;
                else if (wovf) w = '0;
                else w = swa % swb;
            end
            OP_REMUW: w = (wb == '0) ? wa : wa % wb;
            default:  r = '0;
        endcase
        if (op inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                       OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
            r = {{(XLEN-WORD_W){w[WORD_W-1]}}, w};
        end
        return r;
    endfunction

    // ************************************************
    // stimulus
    // ************************************************
    // full four-phase cycle on the op side
    task automatic issue_op(input exu_op_e op, input xlen_t a, input xlen_t b,
                            input reg_addr_t rd);
        exp_val.push_back(ref_exu(op, a, b));
        exp_rd.push_back(rd);
        op_req  <= 1'b1;
        op_code <= op;
        op_a    <= a;
        op_b    <= b;
        op_rd   <= rd;
        do @(posedge clk); while (!op_ack);
        op_req <= 1'b0;
        do @(posedge clk); while (op_ack);
    endtask

    task automatic run_random(input int count, input int kind);
        exu_op_e op;
        xlen_t   a;
        xlen_t   b;
        for (int i = 0; i < count; i++) begin
            op = pick_op(kind);
            a  = pick_operand();
            b  = pick_operand();
            issue_op(op, a, b, reg_addr_t'(stim_bits(REG_ADDR_W)));
        end
    endtask

    // all results back and output handshake closed
    task automatic end_test(input string name, input int err_start);
        do @(posedge clk); while (exp_val.size() != 0 || res_req || res_ack);
        if (total_errors() == err_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, total_errors() - err_start);
        end
    endtask

    initial begin : main_seq
        int err_start;
        rst     = 1'b1;
        op_req  = 1'b0;
        op_code = OP_ADD;
        op_a    = '0;
        op_b    = '0;
        op_rd   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // idle after reset, nothing may come out
        err_start = total_errors();
        @(posedge clk);
        checks++;
        if (op_ack !== 1'b0 || res_req !== 1'b0) begin
            errors++;
            $display("Error at %0t: op_ack %b res_req %b after reset, expected low",
                     $time, op_ack, res_req);
        end
        repeat (20) begin
            @(posedge clk);
            if (res_req !== 1'b0) begin
                errors++;
                $display("Error at %0t: res_req %b with no operation issued", $time, res_req);
            end
        end
        end_test("reset", err_start);

        err_start = total_errors();
        run_random(N_ALU, 0);
        end_test("alu64", err_start);

        err_start = total_errors();
        run_random(N_WORD, 1);
        end_test("word", err_start);

        // random mul/div, then zero divisor and overflow for every divide form
        err_start = total_errors();
        run_random(N_MULDIV, 2);
        for (int i = 0; i < 8; i++) begin
            issue_op(div_ops[i], pick_operand(), '0, reg_addr_t'(i));
            issue_op(div_ops[i], (i < 4) ? MOST_NEG : 64'h0000_0001_8000_0000, '1,
                     reg_addr_t'(i + 8));
        end
        end_test("muldiv", err_start);

        // back-pressure on the result side
        err_start = total_errors();
        ack_max_delay = 7;
        run_random(N_MIXED, 3);
        end_test("mixed", err_start);
        ack_max_delay = 0;

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ************************************************
    // result side, in-order compare
    // ************************************************
    initial begin : result_check
        int        delay;
        xlen_t     want_val;
        reg_addr_t want_rd;
        res_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (res_req === 1'b1) begin
                checks++;
                if (exp_val.size() == 0) begin
                    errors++;
                    $display("unexpected result at %0t: rd %0d value %h, nothing outstanding",
                             $time, res_rd, res_value);
                end else begin
                    want_val = exp_val.pop_front();
                    want_rd  = exp_rd.pop_front();
                    if (res_value !== want_val || res_rd !== want_rd) begin
                        errors++;
                        $display("Error at %0t: got rd %0d value %h, expected rd %0d value %h",
                                 $time, res_rd, res_value, want_rd, want_val);
                    end
                end
                // random stall before taking the result
                delay = (ack_max_delay > 0) ? delay_bits(3) % (ack_max_delay + 1) : 0;
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                do @(posedge clk); while (res_req);
                res_ack <= 1'b0;
            end
        end
    end

    // run length bound, DIV_STEPS + 20 cycles per operation
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles, %0d results still outstanding",
                 TIMEOUT_CYCLES, exp_val.size());
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
source/exu_pkg.sv
source/exu_lane_if.sv
source/exu_dispatch.sv
source/exu_lane.sv
source/exu_retire.sv
source/exu_top.sv
verification/exu_assert.sv
verification/tb_exu.sv

// ==== Makefile ====
# Verilator build and run for the execute unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_exu
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
